/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

   // one data word and one byte address
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   // processor request, held steady until hit
   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
   } cpu_req_t;

   typedef struct packed {
      logic  hit;
      word_t load;
      logic  flushed;
   } cpu_resp_t;

   // one word per memory transfer
   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
   } mem_req_t;

   // transfer completes on a cycle with dwait low
   typedef struct packed {
      logic  dwait;
      word_t load;
   } mem_resp_t;

endpackage

/* design/dcache_pkg.sv */
package dcache_pkg;

   import mem_bus_pkg::*;

   // geometry
   localparam int NUM_WAYS = 2;
   localparam int NUM_SETS = 8;

   // address fields: tag | index | word | byte
   localparam int TAG_W    = 26;
   localparam int INDEX_W  = 3;
   localparam int WORD_BIT = 2;
   localparam int TAG_LSB  = 6;

   typedef logic [TAG_W-1:0]            tag_t;
   typedef logic [INDEX_W-1:0]          index_t;
   typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

   // one stored block as seen at a way's output
   typedef struct packed {
      tag_t        tag;
      logic        valid;
      logic        dirty;
      word_t [1:0] data;
   } way_line_t;

   // write command into a single way
   typedef struct packed {
      logic   en;
      index_t index;
      logic   word_sel;
      logic   data_wr;
      word_t  data;
      logic   fill;
      tag_t   tag;
      logic   set_dirty;
      logic   clr_dirty;
   } way_wr_t;

   // read side presented to every way and to the selector
   typedef struct packed {
      index_t index;
      tag_t   tag;
      logic   word_sel;
      logic   touch;
      logic   force_en;
      way_t   forced_way;
   } lookup_t;

   typedef enum logic [3:0] {
      IDLE, WB1, WB2, READ1, READ2, DIRTY, FLUSH1, FLUSH2, HALT
   } ctrl_state_t;

endpackage

/* design/cache_way.sv */
`timescale 1ns/10ps

module cache_way import mem_bus_pkg::*, dcache_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  lookup_t   lookup,
   input  way_wr_t   wr,
   output way_line_t line,
   output logic      hit
);

   tag_t                tags [NUM_SETS];
   word_t [1:0]         data [NUM_SETS];
   logic [NUM_SETS-1:0] valid;
   logic [NUM_SETS-1:0] dirty;

   // entry at the lookup index, no read latency
   always_comb
   begin
      line.tag   = tags[lookup.index];
      line.valid = valid[lookup.index];
      line.dirty = dirty[lookup.index];
      line.data  = data[lookup.index];
   end

   assign hit = valid[lookup.index] && (tags[lookup.index] == lookup.tag);

   // block payload
   always_ff @(posedge CLK)
   begin
      if (wr.en && wr.data_wr)
      begin
         data[wr.index][wr.word_sel] <= wr.data;
      end
      if (wr.en && wr.fill)
      begin
         tags[wr.index] <= wr.tag;
      end
   end

   // state bits per set
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         valid <= '0;
         dirty <= '0;
      end
      else if (wr.en)
      begin
         if (wr.fill)
         begin
            valid[wr.index] <= 1'b1;
         end
         if (wr.set_dirty)
         begin
            dirty[wr.index] <= 1'b1;
         end
         else if (wr.clr_dirty)
         begin
            dirty[wr.index] <= 1'b0;
         end
      end
   end

   // controller never asks for both dirty updates at once
   a_dirty_excl: assert property (@(posedge CLK) disable iff (nRST == 1'b0)
      wr.en |-> !(wr.set_dirty && wr.clr_dirty));

endmodule

/* design/way_select.sv */
`timescale 1ns/10ps

module way_select import mem_bus_pkg::*, dcache_pkg::*;
(
   input  logic                     CLK,
   input  logic                     nRST,
   input  lookup_t                  lookup,
   input  way_line_t [NUM_WAYS-1:0] lines,
   input  logic      [NUM_WAYS-1:0] way_hits,
   output logic                     hit,
   output word_t                    load,
   output way_t                     victim,
   output way_line_t                victim_line
);

   // way touched last, one entry per set
   way_t [NUM_SETS-1:0] last_used;
   way_t                hit_way;

   assign hit = |way_hits;

   // with two ways the upper hit bit names the hitting way
   assign hit_way = way_hits[NUM_WAYS-1];

   assign load = lines[hit_way].data[lookup.word_sel];

   // flush walks the ways by force, misses take the older way
   always_comb
   begin
      if (lookup.force_en)
      begin
         victim = lookup.forced_way;
      end
      else
      begin
         victim = ~last_used[lookup.index];
      end
   end

   assign victim_line = lines[victim];

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         last_used <= '0;
      end
      else if (lookup.touch && hit)
      begin
         last_used[lookup.index] <= hit_way;
      end
   end

   // a block lives in one way only, so a fill never duplicates a tag
   a_one_way_hit: assert property (@(posedge CLK) disable iff (nRST == 1'b0)
      !(way_hits[0] && way_hits[1]));

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl import mem_bus_pkg::*, dcache_pkg::*;
(
   input  logic                   CLK,
   input  logic                   nRST,
   input  cpu_req_t               cpu_req,
   input  logic                   halt,
   input  logic                   hit,
   input  word_t                  load,
   input  way_t                   victim,
   input  way_line_t              victim_line,
   output lookup_t                lookup,
   output way_wr_t [NUM_WAYS-1:0] way_wr,
   output cpu_resp_t              cpu_resp,
   output mem_req_t               mem_req,
   input  mem_resp_t              mem_resp
);

   ctrl_state_t state, next_state;
   // flush position, top bit selects the way
   logic [INDEX_W:0] row, next_row;
   logic             last_wen, next_last_wen;

   logic    req;
   logic    ready;
   logic    second;
   logic    victim_dirty;
   logic    last_row;
   tag_t    req_tag;
   index_t  req_index;
   way_t    hit_way;
   way_t    tgt;
   way_wr_t cmd;

   assign req          = cpu_req.ren || cpu_req.wen;
   assign ready        = !mem_resp.dwait;
   assign second       = state inside {WB2, READ2, FLUSH2};
   assign req_tag      = cpu_req.addr[TAG_LSB +: TAG_W];
   assign req_index    = cpu_req.addr[TAG_LSB-1 -: INDEX_W];
   assign victim_dirty = victim_line.valid && victim_line.dirty;
   assign last_row     = (row == '1);

   // selector only says some way hit
   // if the victim line matches, the victim is the hit way
   assign hit_way = (victim_line.valid && (victim_line.tag == req_tag)) ? victim : ~victim;

   always_comb
   begin
      lookup          = '0;
      lookup.tag      = req_tag;
      lookup.word_sel = cpu_req.addr[WORD_BIT];
      if (state inside {DIRTY, FLUSH1, FLUSH2, HALT})
      begin
         lookup.index      = row[INDEX_W-1:0];
         lookup.force_en   = 1'b1;
         lookup.forced_way = row[INDEX_W];
      end
      else
      begin
         lookup.index = req_index;
         lookup.touch = (state == IDLE) && req;
      end
   end

   always_comb
   begin
      next_state    = state;
      next_row      = row;
      next_last_wen = last_wen;
      case (state)
         IDLE:
         begin
            if (halt)
            begin
               next_row   = '0;
               next_state = DIRTY;
            end
            else if (req && !hit)
            begin
               next_last_wen = cpu_req.wen;
               next_state    = victim_dirty ? WB1 : READ1;
            end
         end
         WB1:
         begin
            if (ready)
            begin
               next_state = WB2;
            end
         end
         WB2:
         begin
            if (ready)
            begin
               next_state = READ1;
            end
         end
         READ1:
         begin
            if (ready)
            begin
               next_state = READ2;
            end
         end
         READ2:
         begin
            if (ready)
            begin
               next_state = IDLE;
            end
         end
         // one cycle per entry, dirty ones detour through the flush writes
         DIRTY:
         begin
            if (victim_dirty)
            begin
               next_state = FLUSH1;
            end
            else if (last_row)
            begin
               next_state = HALT;
            end
            else
            begin
               next_row = row + 1'b1;
            end
         end
         FLUSH1:
         begin
            if (ready)
            begin
               next_state = FLUSH2;
            end
         end
         FLUSH2:
         begin
            if (ready)
            begin
               next_state = last_row ? HALT : DIRTY;
               next_row   = row + 1'b1;
            end
         end
         HALT:
         begin
            next_state = HALT;
         end
         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

   // one command per cycle, steered to a single way
   always_comb
   begin
      cmd       = '0;
      cmd.index = lookup.index;
      cmd.tag   = req_tag;
      tgt       = victim;
      mem_req   = '0;
      case (state)
         IDLE:
         begin
            if (cpu_req.wen && hit)
            begin
               cmd.en        = 1'b1;
               cmd.word_sel  = cpu_req.addr[WORD_BIT];
               cmd.data_wr   = 1'b1;
               cmd.data      = cpu_req.store;
               cmd.set_dirty = 1'b1;
               tgt           = hit_way;
            end
         end
         WB1, WB2, FLUSH1, FLUSH2:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = {victim_line.tag, lookup.index, second, 2'b00};
            mem_req.store = victim_line.data[second];
            cmd.en        = ready && second;
            cmd.clr_dirty = 1'b1;
         end
         READ1, READ2:
         begin
            mem_req.ren   = 1'b1;
            mem_req.addr  = {req_tag, req_index, second, 2'b00};
            cmd.en        = ready;
            cmd.word_sel  = second;
            cmd.data_wr   = 1'b1;
            cmd.data      = mem_resp.load;
            cmd.fill      = second;
            cmd.set_dirty = second && last_wen;
         end
         default:
         begin
            cmd.en = 1'b0;
         end
      endcase
      way_wr      = '0;
      way_wr[tgt] = cmd;
   end

   always_comb
   begin
      cpu_resp.hit     = (state == IDLE) && req && hit;
      cpu_resp.load    = load;
      cpu_resp.flushed = (state == HALT);
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         state    <= IDLE;
         row      <= '0;
         last_wen <= 1'b0;
      end
      else
      begin
         state    <= next_state;
         row      <= next_row;
         last_wen <= next_last_wen;
      end
   end

   a_one_strobe: assert property (@(posedge CLK) disable iff (nRST == 1'b0)
      !(mem_req.ren && mem_req.wen));

   // miss handling reads the index and tag straight from the request
   a_addr_held: assert property (@(posedge CLK) disable iff (nRST == 1'b0)
      (req && !cpu_resp.hit && !halt) |=> $stable(cpu_req.addr));

endmodule

/* design/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top import mem_bus_pkg::*, dcache_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  cpu_req_t  cpu_req,
   input  logic      halt,
   output cpu_resp_t cpu_resp,
   output mem_req_t  mem_req,
   input  mem_resp_t mem_resp
);

   lookup_t                  lookup;
   way_wr_t   [NUM_WAYS-1:0] way_wr;
   way_line_t [NUM_WAYS-1:0] lines;
   logic      [NUM_WAYS-1:0] way_hits;
   logic                     hit;
   word_t                    load;
   way_t                     victim;
   way_line_t                victim_line;

   dcache_ctrl u_ctrl (
      .CLK         (CLK),
      .nRST        (nRST),
      .cpu_req     (cpu_req),
      .halt        (halt),
      .hit         (hit),
      .load        (load),
      .victim      (victim),
      .victim_line (victim_line),
      .lookup      (lookup),
      .way_wr      (way_wr),
      .cpu_resp    (cpu_resp),
      .mem_req     (mem_req),
      .mem_resp    (mem_resp)
   );

   for (genvar g = 0; g < NUM_WAYS; g++)
   begin : g_way
      cache_way u_way (
         .CLK    (CLK),
         .nRST   (nRST),
         .lookup (lookup),
         .wr     (way_wr[g]),
         .line   (lines[g]),
         .hit    (way_hits[g])
      );
   end

   way_select u_sel (
      .CLK         (CLK),
      .nRST        (nRST),
      .lookup      (lookup),
      .lines       (lines),
      .way_hits    (way_hits),
      .hit         (hit),
      .load        (load),
      .victim      (victim),
      .victim_line (victim_line)
   );

endmodule

/* dv/ram_model.sv */
`timescale 1ns/10ps

module ram_model import mem_bus_pkg::*;
(
   input  logic      CLK,
   input  logic      stall,
   input  mem_req_t  mem_req,
   output mem_resp_t mem_resp
);

   localparam int WORDS = 256;
   localparam int AW    = 8;

   word_t            mem [WORDS];
   // write log, one flag per word and a running count
   logic [WORDS-1:0] wr_log;
   int               wr_count;
   logic [AW-1:0]    idx;
   addr_t            fill_addr;

   assign idx            = mem_req.addr[AW+1:2];
   assign mem_resp.dwait = stall;
   assign mem_resp.load  = mem[idx];

   // each word starts as its byte address with the halves swapped
   initial
   begin
      for (int i = 0; i < WORDS; i++)
      begin
         fill_addr = addr_t'(i) << 2;
         mem[i]    = {fill_addr[15:0], fill_addr[31:16]};
      end
      wr_log   = '0;
      wr_count = 0;
   end

   always @(posedge CLK)
   begin
      if (mem_req.wen && !stall)
      begin
         mem[idx]    <= mem_req.store;
         wr_log[idx] <= 1'b1;
         wr_count    <= wr_count + 1;
      end
   end

endmodule

/* dv/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb import mem_bus_pkg::*;
;

   localparam int WORDS        = 256;
   localparam int PERIOD       = 20;
   localparam int N_RAND       = 48;
   localparam int NUM_OPS      = 16 + 32 + 6 + N_RAND;
   // two write-backs and two fills with stalls, plus the gap between requests
   localparam int MISS_CYCLES  = 48;
   localparam int FLUSH_CYCLES = 16 * (1 + 2 * 16);
   localparam int TIMEOUT      = (NUM_OPS * MISS_CYCLES + FLUSH_CYCLES + 10) * PERIOD;

   // three blocks of set 5 with tags 2, 3 and 4
   localparam addr_t BLK_A = 32'd168;
   localparam addr_t BLK_B = 32'd232;
   localparam addr_t BLK_C = 32'd296;

   logic             CLK;
   logic             nRST;
   logic             halt;
   logic             stall;
   cpu_req_t         cpu_req;
   cpu_resp_t        cpu_resp;
   mem_req_t         mem_req;
   mem_resp_t        mem_resp;
   logic             first;
   logic             expect_fast;
   logic             expect_miss;
   word_t            shadow [WORDS];
   logic [WORDS-1:0] was_written;
   word_t            exp_load;
   word_t            exp_wb;
   logic             exp_dirty;
   logic [31:0]      stall_rng;
   logic [31:0]      data_rng;
   int               errors;
   int               ops;
   addr_t            a;
   word_t            d;

   dcache_top DUT (
      .CLK      (CLK),
      .nRST     (nRST),
      .cpu_req  (cpu_req),
      .halt     (halt),
      .cpu_resp (cpu_resp),
      .mem_req  (mem_req),
      .mem_resp (mem_resp)
   );

   ram_model u_ram (
      .CLK      (CLK),
      .stall    (stall),
      .mem_req  (mem_req),
      .mem_resp (mem_resp)
   );

   assign exp_load  = shadow[cpu_req.addr[9:2]];
   assign exp_wb    = shadow[mem_req.addr[9:2]];

   // a store to either word makes the whole block due for write-back
   assign exp_dirty = was_written[{mem_req.addr[9:3], 1'b0}] ||
                      was_written[{mem_req.addr[9:3], 1'b1}];

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // one request held until hit, then one idle cycle
   task automatic cache_access(input logic wr, input addr_t addr, input word_t data,
                               input logic fast, input logic miss);
      logic done;
      @(posedge CLK);
      cpu_req     <= '{ren: !wr, wen: wr, addr: addr, store: data};
      first       <= 1'b1;
      expect_fast <= fast;
      expect_miss <= miss;
      done = 1'b0;
      while (!done)
      begin
         @(negedge CLK);
         done = cpu_resp.hit;
         @(posedge CLK);
         first <= 1'b0;
      end
      cpu_req     <= '0;
      expect_fast <= 1'b0;
      expect_miss <= 1'b0;
      if (wr)
      begin
         shadow[addr[9:2]]      = data;
         was_written[addr[9:2]] = 1'b1;
      end
      ops++;
   endtask

   initial
   begin
      CLK = 1'b0;
      forever #(PERIOD / 2) CLK = ~CLK;
   end

   // memory stalls about one cycle in four
   always @(posedge CLK)
   begin
      stall_rng <= xorshift(stall_rng);
      stall     <= (stall_rng[1:0] == 2'b00);
   end

   a_reset_quiet: assert property (@(posedge CLK) (!nRST || $past(!nRST)) |->
      !(cpu_resp.hit || cpu_resp.flushed || mem_req.ren || mem_req.wen))
      else begin errors++; $display("hit, flushed or a memory strobe was high around reset"); end

   a_load: assert property (@(posedge CLK) disable iff (!nRST)
      (cpu_req.ren && cpu_resp.hit) |-> (cpu_resp.load == exp_load))
      else begin
         errors++;
         $display("error cpu_resp.load: got %h expected %h",
                  $sampled(cpu_resp.load), $sampled(exp_load));
      end

   a_fast_hit: assert property (@(posedge CLK) disable iff (!nRST)
      (first && expect_fast) |-> cpu_resp.hit)
      else begin errors++; $display("a resident block did not hit in its first cycle"); end

   a_evicted: assert property (@(posedge CLK) disable iff (!nRST)
      (first && expect_miss) |-> !cpu_resp.hit)
      else begin errors++; $display("the LRU victim still hit in its first cycle"); end

   a_wb_data: assert property (@(posedge CLK) disable iff (!nRST)
      mem_req.wen |-> (mem_req.store == exp_wb))
      else begin
         errors++;
         $display("error mem_req.store: got %h expected %h",
                  $sampled(mem_req.store), $sampled(exp_wb));
      end

   a_wb_written: assert property (@(posedge CLK) disable iff (!nRST)
      mem_req.wen |-> exp_dirty)
      else begin errors++; $display("a memory write came from a block never stored to"); end

   a_flush_held: assert property (@(posedge CLK) disable iff (!nRST)
      cpu_resp.flushed |=> cpu_resp.flushed)
      else begin errors++; $display("flushed dropped after it rose"); end

   a_flush_quiet: assert property (@(posedge CLK) disable iff (!nRST)
      cpu_resp.flushed |-> (halt && !(mem_req.ren || mem_req.wen)))
      else begin errors++; $display("flushed without halt, or a memory strobe after it"); end

   initial
   begin
      #(TIMEOUT);
      $display("timeout: the run did not finish in the expected time");
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      nRST        = 1'b0;
      halt        = 1'b0;
      stall       = 1'b0;
      cpu_req     = '0;
      first       = 1'b0;
      expect_fast = 1'b0;
      expect_miss = 1'b0;
      was_written = '0;
      stall_rng   = 32'h7bb;
      data_rng    = 32'h7bb;
      errors      = 0;
      ops         = 0;
      for (int i = 0; i < WORDS; i++)
      begin
         a         = addr_t'(i) << 2;
         shadow[i] = {a[15:0], a[31:16]};
      end
      repeat (3) @(posedge CLK);
      nRST <= 1'b1;

      // sixteen blocks fill both ways of every set
      for (int b = 0; b < 16; b++)
      begin
         data_rng = xorshift(data_rng);
         a = (addr_t'(b) << 3) | (addr_t'(data_rng[8]) << 2);
         cache_access(1'b1, a, data_rng, 1'b0, 1'b0);
      end
      for (int b = 0; b < 16; b++)
      begin
         for (int w = 0; w < 2; w++)
         begin
            a = (addr_t'(b) << 3) | (addr_t'(w) << 2);
            cache_access(1'b0, a, '0, 1'b1, 1'b0);
         end
      end

      // A, B, A, then C evicts B
      data_rng = xorshift(data_rng);
      cache_access(1'b0, BLK_A, '0, 1'b0, 1'b0);
      cache_access(1'b1, BLK_B, data_rng, 1'b0, 1'b0);
      cache_access(1'b0, BLK_A, '0, 1'b1, 1'b0);
      cache_access(1'b0, BLK_C, '0, 1'b0, 1'b0);
      cache_access(1'b0, BLK_A, '0, 1'b1, 1'b0);
      cache_access(1'b0, BLK_B, '0, 1'b0, 1'b1);

      for (int i = 0; i < N_RAND; i++)
      begin
         data_rng = xorshift(data_rng);
         a = addr_t'(data_rng[8:2]) << 2;
         d = xorshift(data_rng ^ 32'h5a5a_0f0f);
         cache_access(data_rng[9], a, d, 1'b0, 1'b0);
      end

      @(posedge CLK);
      halt <= 1'b1;
      @(negedge CLK);
      while (!cpu_resp.flushed)
      begin
         @(negedge CLK);
      end
      repeat (4) @(posedge CLK);

      for (int i = 0; i < WORDS; i++)
      begin
         assert (u_ram.mem[i] == shadow[i])
         else begin
            errors++;
            $display("error u_ram.mem[%0d]: got %h expected %h", i, u_ram.mem[i], shadow[i]);
         end
         // a stored word reaches memory through an eviction or the flush
         assert (!was_written[i] || u_ram.wr_log[i])
         else begin
            errors++;
            $display("word %0d was stored to but never written to memory", i);
         end
      end

      $display("ops %0d, memory writes %0d, errors %0d", ops, u_ram.wr_count, errors);
      if (errors == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* dcache_top.f */
design/mem_bus_pkg.sv
design/dcache_pkg.sv
design/cache_way.sv
design/way_select.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/ram_model.sv
dv/dcache_tb.sv
